/* ex_alu.sv */
/*
 * integer, word, upper-immediate and link results,
 * branch condition and branch target
 */
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_alu (
    input  ex_pipe_pkg::ex_op_t  op_i,
    output logic [`EX_XLEN-1:0]  alu_data_o,
    output logic                 br_taken_o,
    output logic [`EX_XLEN-1:0]  br_target_o
);

    localparam int SW = ex_isa_pkg::SHAMT_W;

    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic                lt_s;
    logic                lt_u;
    logic [31:0]         w_add;
    logic [31:0]         w_sub;
    logic [31:0]         w_sll;
    logic [31:0]         w_srl;
    logic [31:0]         w_sra;

    function automatic logic [`EX_XLEN-1:0] sext_w(input logic [31:0] w);
        return {{(`EX_XLEN-32){w[31]}}, w};
    endfunction

    assign a    = op_i.op1;
    assign b    = op_i.op2.value;
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    // word ops only look at the low halves
    assign w_add = a[31:0] + b[31:0];
    assign w_sub = a[31:0] - b[31:0];
    assign w_sll = a[31:0] << b[SW-2:0];
    assign w_srl = a[31:0] >> b[SW-2:0];
    assign w_sra = $signed(a[31:0]) >>> b[SW-2:0];

    always_comb begin
        case (op_i.opcode)
            ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDI:   alu_data_o = a + b;
            ex_isa_pkg::OP_SUB:                        alu_data_o = a - b;
            ex_isa_pkg::OP_SLL, ex_isa_pkg::OP_SLLI:   alu_data_o = a << b[SW-1:0];
            ex_isa_pkg::OP_SLT, ex_isa_pkg::OP_SLTI:   alu_data_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
            ex_isa_pkg::OP_SLTU, ex_isa_pkg::OP_SLTIU: alu_data_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
            ex_isa_pkg::OP_XOR, ex_isa_pkg::OP_XORI:   alu_data_o = a ^ b;
            ex_isa_pkg::OP_SRL, ex_isa_pkg::OP_SRLI:   alu_data_o = a >> b[SW-1:0];
            ex_isa_pkg::OP_SRA, ex_isa_pkg::OP_SRAI:   alu_data_o = $signed(a) >>> b[SW-1:0];
            ex_isa_pkg::OP_OR, ex_isa_pkg::OP_ORI:     alu_data_o = a | b;
            ex_isa_pkg::OP_AND, ex_isa_pkg::OP_ANDI:   alu_data_o = a & b;
            ex_isa_pkg::OP_ADDW, ex_isa_pkg::OP_ADDIW: alu_data_o = sext_w(w_add);
            ex_isa_pkg::OP_SUBW:                       alu_data_o = sext_w(w_sub);
            ex_isa_pkg::OP_SLLW, ex_isa_pkg::OP_SLLIW: alu_data_o = sext_w(w_sll);
            ex_isa_pkg::OP_SRLW, ex_isa_pkg::OP_SRLIW: alu_data_o = sext_w(w_srl);
            ex_isa_pkg::OP_SRAW, ex_isa_pkg::OP_SRAIW: alu_data_o = sext_w(w_sra);
            ex_isa_pkg::OP_LUI:                        alu_data_o = op_i.imm;
            ex_isa_pkg::OP_AUIPC:                      alu_data_o = op_i.pc + op_i.imm;
            // link value
            ex_isa_pkg::OP_JAL, ex_isa_pkg::OP_JALR:   alu_data_o = op_i.pc + 'd4;
            default:                                   alu_data_o = '0;
        endcase
    end

    always_comb begin
        case (op_i.opcode)
            ex_isa_pkg::OP_BEQ:  br_taken_o = (a == b);
            ex_isa_pkg::OP_BNE:  br_taken_o = (a != b);
            ex_isa_pkg::OP_BLT:  br_taken_o = lt_s;
            ex_isa_pkg::OP_BGE:  br_taken_o = ~lt_s;
            ex_isa_pkg::OP_BLTU: br_taken_o = lt_u;
            ex_isa_pkg::OP_BGEU: br_taken_o = ~lt_u;
            default:             br_taken_o = 1'b0;
        endcase
    end

    assign br_target_o = op_i.pc + op_i.imm;

endmodule

/* ex_csr.sv */
/*
 * machine CSR file with read-modify-write ops,
 * ECALL and timer trap entry, MRET return
 */
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_csr (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  ex_pipe_pkg::ex_op_t  op_i,
    input  logic                 op_valid_i,
    input  logic                 timer_irq_i,
    output logic [`EX_XLEN-1:0]  csr_rdata_o,
    output logic                 trap_take_o,
    output logic [`EX_XLEN-1:0]  trap_pc_o,
    output logic                 irq_take_o
);

    localparam int MIE  = ex_isa_pkg::MSTATUS_MIE;
    localparam int MPIE = ex_isa_pkg::MSTATUS_MPIE;

    logic [`EX_XLEN-1:0] mstatus;
    logic [`EX_XLEN-1:0] mtvec;
    logic [`EX_XLEN-1:0] mscratch;
    logic [`EX_XLEN-1:0] mepc;
    logic [`EX_XLEN-1:0] mcause;

    logic [11:0]         csr_idx;
    logic [`EX_XLEN-1:0] csr_rdata;
    logic [`EX_XLEN-1:0] csr_wdata;
    logic                csr_wr;
    logic                is_ecall;
    logic                is_mret;

    assign csr_idx  = op_i.op2.csr.idx;
    assign is_ecall = (op_i.opcode == ex_isa_pkg::OP_ECALL);
    assign is_mret  = (op_i.opcode == ex_isa_pkg::OP_MRET);

    always_comb begin
        case (csr_idx)
            ex_isa_pkg::CSR_MSTATUS:  csr_rdata = mstatus;
            ex_isa_pkg::CSR_MTVEC:    csr_rdata = mtvec;
            ex_isa_pkg::CSR_MSCRATCH: csr_rdata = mscratch;
            ex_isa_pkg::CSR_MEPC:     csr_rdata = mepc;
            ex_isa_pkg::CSR_MCAUSE:   csr_rdata = mcause;
            default:                  csr_rdata = '0;
        endcase
    end

    // set/clear with a zero mask leave the register alone
    always_comb begin
        csr_wr    = 1'b0;
        csr_wdata = op_i.op1;
        case (op_i.opcode)
            ex_isa_pkg::OP_CSRRW, ex_isa_pkg::OP_CSRRWI: begin
                csr_wr = 1'b1;
            end
            ex_isa_pkg::OP_CSRRS, ex_isa_pkg::OP_CSRRSI: begin
                csr_wr    = |op_i.op1;
                csr_wdata = csr_rdata | op_i.op1;
            end
            ex_isa_pkg::OP_CSRRC, ex_isa_pkg::OP_CSRRCI: begin
                csr_wr    = |op_i.op1;
                csr_wdata = csr_rdata & ~op_i.op1;
            end
            default: ;
        endcase
    end

    // interrupt wins over whatever the op is
    assign irq_take_o  = timer_irq_i & mstatus[MIE];
    assign trap_take_o = irq_take_o | is_ecall | is_mret;
    assign trap_pc_o   = (is_mret && !irq_take_o) ? mepc : mtvec;
    assign csr_rdata_o = csr_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mstatus  <= '0;
            mtvec    <= `EX_MTVEC_RESET;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (op_valid_i) begin
            if (irq_take_o || is_ecall) begin
                mepc          <= op_i.pc;
                mcause        <= irq_take_o ? `EX_CAUSE_MTIMER : `EX_CAUSE_ECALL;
                mstatus[MPIE] <= mstatus[MIE];
                mstatus[MIE]  <= 1'b0;
            end else if (is_mret) begin
                mstatus[MIE]  <= mstatus[MPIE];
                mstatus[MPIE] <= 1'b1;
            end else if (csr_wr) begin
                case (csr_idx)
                    ex_isa_pkg::CSR_MSTATUS:  mstatus  <= csr_wdata;
                    ex_isa_pkg::CSR_MTVEC:    mtvec    <= csr_wdata;
                    ex_isa_pkg::CSR_MSCRATCH: mscratch <= csr_wdata;
                    ex_isa_pkg::CSR_MEPC:     mepc     <= csr_wdata;
                    ex_isa_pkg::CSR_MCAUSE:   mcause   <= csr_wdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* ex_defs.svh */
/*
 * data width, mtvec reset value and trap cause codes
 */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// integer register and address width
`define EX_XLEN 64

// trap vector after reset
`define EX_MTVEC_RESET 64'h0000_0000_8000_0000

// mcause codes
`define EX_CAUSE_ECALL  64'd11
`define EX_CAUSE_MTIMER 64'h8000_0000_0000_0007

`endif

/* ex_isa_pkg.sv */
/*
 * executed opcode enumeration, machine CSR addresses,
 * mstatus bit positions and opcode class helpers
 */
`include "ex_defs.svh"

package ex_isa_pkg;

    // shift amount width for full-width shifts
    localparam int SHAMT_W = $clog2(`EX_XLEN);

    typedef enum logic [7:0] {
        OP_NOP,
        OP_ADD, OP_ADDI, OP_SUB, OP_SLL, OP_SLLI, OP_SLT, OP_SLTI,
        OP_SLTU, OP_SLTIU, OP_XOR, OP_XORI, OP_SRL, OP_SRLI, OP_SRA, OP_SRAI,
        OP_OR, OP_ORI, OP_AND, OP_ANDI,
        OP_ADDW, OP_ADDIW, OP_SUBW, OP_SLLW, OP_SLLIW, OP_SRLW, OP_SRLIW,
        OP_SRAW, OP_SRAIW,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
        OP_ECALL, OP_MRET
    } ex_opcode_e;

    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // rd takes the old CSR value for these
    function automatic logic is_csr_op(input ex_opcode_e op);
        return op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
    endfunction

endpackage

/* ex_issue.sv */
/*
 * four-phase receiver for the operation channel
 */
`timescale 1ns/1ps

module ex_issue (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                op_req_i,
    input  ex_pipe_pkg::ex_op_t op_i,
    input  logic                busy_i,
    output logic                op_ack_o,
    output ex_pipe_pkg::ex_op_t op_o,
    output logic                op_valid_o
);

    logic accept;

    // new request, previous handshake closed, retire side free
    assign accept = op_req_i & ~op_ack_o & ~busy_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            op_ack_o   <= 1'b0;
            op_valid_o <= 1'b0;
        end else begin
            op_valid_o <= accept;
            if (accept) begin
                op_ack_o <= 1'b1;
            end else if (!op_req_i && op_ack_o) begin
                op_ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_o <= op_i;
        end
    end

endmodule

/* ex_pipe_pkg.sv */
/*
 * operand union with its CSR view, the decoded operation record
 * and the result record passed between execute blocks
 */
`include "ex_defs.svh"

package ex_pipe_pkg;

    // second operand seen as a CSR selector
    typedef struct packed {
        logic [`EX_XLEN-13:0] unused;
        logic [11:0]          idx;
    } ex_csr_sel_t;

    typedef union packed {
        logic [`EX_XLEN-1:0] value;
        ex_csr_sel_t         csr;
    } ex_operand_u;

    typedef struct packed {
        logic [`EX_XLEN-1:0]    pc;
        ex_isa_pkg::ex_opcode_e opcode;
        logic [`EX_XLEN-1:0]    op1;
        ex_operand_u            op2;
        // sign-extended branch or upper immediate
        logic [`EX_XLEN-1:0]    imm;
        logic [4:0]             rd_addr;
        logic                   rd_ena;
    } ex_op_t;

    typedef struct packed {
        logic                rd_ena;
        logic [4:0]          rd_addr;
        logic [`EX_XLEN-1:0] rd_data;
        logic                redirect_ena;
        logic [`EX_XLEN-1:0] redirect_pc;
    } ex_res_t;

endpackage

/* ex_retire.sv */
/*
 * result merge, result register and four-phase sender
 */
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_retire (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  ex_pipe_pkg::ex_op_t  op_i,
    input  logic                 op_valid_i,
    input  logic [`EX_XLEN-1:0]  alu_data_i,
    input  logic                 br_taken_i,
    input  logic [`EX_XLEN-1:0]  br_target_i,
    input  logic [`EX_XLEN-1:0]  csr_rdata_i,
    input  logic                 trap_take_i,
    input  logic [`EX_XLEN-1:0]  trap_pc_i,
    input  logic                 irq_take_i,
    input  logic                 res_ack_i,
    output logic                 res_req_o,
    output ex_pipe_pkg::ex_res_t res_o,
    output logic                 busy_o
);

    ex_pipe_pkg::ex_res_t res_d;

    always_comb begin
        res_d.rd_ena       = op_i.rd_ena & ~irq_take_i;
        res_d.rd_addr      = op_i.rd_addr;
        res_d.rd_data      = ex_isa_pkg::is_csr_op(op_i.opcode) ? csr_rdata_i : alu_data_i;
        // trap target beats a taken branch
        res_d.redirect_ena = trap_take_i | br_taken_i;
        res_d.redirect_pc  = trap_take_i ? trap_pc_i : br_target_i;
    end

    always_ff @(posedge clk) begin
        if (op_valid_i) begin
            res_o <= res_d;
        end
    end

    // busy covers the whole output handshake
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_req_o <= 1'b0;
            busy_o    <= 1'b0;
        end else if (op_valid_i) begin
            res_req_o <= 1'b1;
            busy_o    <= 1'b1;
        end else if (res_req_o && res_ack_i) begin
            res_req_o <= 1'b0;
        end else if (!res_req_o && busy_o && !res_ack_i) begin
            busy_o <= 1'b0;
        end
    end

endmodule

/* ex_top.sv */
/*
 * execute stage top: issue, ALU, CSR file and retire
 */
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 op_req_i,
    input  ex_pipe_pkg::ex_op_t  op_i,
    output logic                 op_ack_o,
    input  logic                 timer_irq_i,
    output logic                 res_req_o,
    output ex_pipe_pkg::ex_res_t res_o,
    input  logic                 res_ack_i
);

    ex_pipe_pkg::ex_op_t cur_op;
    logic                op_valid;
    logic                busy;
    logic [`EX_XLEN-1:0] alu_data;
    logic                br_taken;
    logic [`EX_XLEN-1:0] br_target;
    logic [`EX_XLEN-1:0] csr_rdata;
    logic                trap_take;
    logic [`EX_XLEN-1:0] trap_pc;
    logic                irq_take;

    ex_issue u_issue (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .op_req_i   (op_req_i),
        .op_i       (op_i),
        .busy_i     (busy),
        .op_ack_o   (op_ack_o),
        .op_o       (cur_op),
        .op_valid_o (op_valid)
    );

    ex_alu u_alu (
        .op_i        (cur_op),
        .alu_data_o  (alu_data),
        .br_taken_o  (br_taken),
        .br_target_o (br_target)
    );

    ex_csr u_csr (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .op_i        (cur_op),
        .op_valid_i  (op_valid),
        .timer_irq_i (timer_irq_i),
        .csr_rdata_o (csr_rdata),
        .trap_take_o (trap_take),
        .trap_pc_o   (trap_pc),
        .irq_take_o  (irq_take)
    );

    ex_retire u_retire (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .op_i        (cur_op),
        .op_valid_i  (op_valid),
        .alu_data_i  (alu_data),
        .br_taken_i  (br_taken),
        .br_target_i (br_target),
        .csr_rdata_i (csr_rdata),
        .trap_take_i (trap_take),
        .trap_pc_i   (trap_pc),
        .irq_take_i  (irq_take),
        .res_ack_i   (res_ack_i),
        .res_req_o   (res_req_o),
        .res_o       (res_o),
        .busy_o      (busy)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the execute-stage testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module tb_ex_top -o sim_ex \
    && ./obj_dir/sim_ex > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* tb_ex_top.sv */
/*
 * testbench for the execute stage: four-phase producer and consumer,
 * reference model with its own CSR copy, result comparison and report
 */
`timescale 1ns/1ps
`include "ex_defs.svh"

module tb_ex_top;

    // about 300 operations at about 10 cycles each, with margin
    localparam int MAX_CYCLES = 6000;

    typedef struct packed {
        logic [63:0] mstatus;
        logic [63:0] mtvec;
        logic [63:0] mscratch;
        logic [63:0] mepc;
        logic [63:0] mcause;
    } csr_state_t;

    logic                 clk;
    logic                 rst_n_i;
    logic                 op_req_i;
    ex_pipe_pkg::ex_op_t  op_i;
    logic                 op_ack_o;
    logic                 timer_irq_i;
    logic                 res_req_o;
    ex_pipe_pkg::ex_res_t res_o;
    logic                 res_ack_i;

    ex_pipe_pkg::ex_res_t exp_q[$];
    csr_state_t           csr_model;
    int                   n_sent = 0;
    int                   n_checked = 0;
    int                   n_errors = 0;
    int                   cycles = 0;

    ex_top dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .op_req_i    (op_req_i),
        .op_i        (op_i),
        .op_ack_o    (op_ack_o),
        .timer_irq_i (timer_irq_i),
        .res_req_o   (res_req_o),
        .res_o       (res_o),
        .res_ack_i   (res_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d, results checked: %0d of %0d", n_errors, n_checked, n_sent);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [63:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // expected record per RV64 rules; updates the CSR copy as the op retires
    function automatic ex_pipe_pkg::ex_res_t ref_exec(input ex_pipe_pkg::ex_op_t op,
                                                      input logic irq,
                                                      inout csr_state_t c);
        ex_pipe_pkg::ex_res_t r;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] old;
        logic [63:0] nxt;
        logic [11:0] idx;
        logic        take_irq;
        logic        wr;
        a = op.op1;
        b = op.op2.value;
        idx = b[11:0];
        take_irq = irq & c.mstatus[ex_isa_pkg::MSTATUS_MIE];
        r.rd_ena = op.rd_ena & ~take_irq;
        r.rd_addr = op.rd_addr;
        r.rd_data = '0;
        r.redirect_ena = 1'b0;
        r.redirect_pc = op.pc + op.imm;
        case (idx)
            ex_isa_pkg::CSR_MSTATUS:  old = c.mstatus;
            ex_isa_pkg::CSR_MTVEC:    old = c.mtvec;
            ex_isa_pkg::CSR_MSCRATCH: old = c.mscratch;
            ex_isa_pkg::CSR_MEPC:     old = c.mepc;
            ex_isa_pkg::CSR_MCAUSE:   old = c.mcause;
            default:                  old = '0;
        endcase
        wr = 1'b0;
        nxt = a;
        case (op.opcode)
            ex_isa_pkg::OP_ADD, ex_isa_pkg::OP_ADDI:   r.rd_data = a + b;
            ex_isa_pkg::OP_SUB:                        r.rd_data = a - b;
            ex_isa_pkg::OP_SLL, ex_isa_pkg::OP_SLLI:   r.rd_data = a << b[5:0];
            ex_isa_pkg::OP_SLT, ex_isa_pkg::OP_SLTI:
                r.rd_data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            ex_isa_pkg::OP_SLTU, ex_isa_pkg::OP_SLTIU: r.rd_data = (a < b) ? 64'd1 : 64'd0;
            ex_isa_pkg::OP_XOR, ex_isa_pkg::OP_XORI:   r.rd_data = a ^ b;
            ex_isa_pkg::OP_SRL, ex_isa_pkg::OP_SRLI:   r.rd_data = a >> b[5:0];
            ex_isa_pkg::OP_SRA, ex_isa_pkg::OP_SRAI:   r.rd_data = $signed(a) >>> b[5:0];
            ex_isa_pkg::OP_OR, ex_isa_pkg::OP_ORI:     r.rd_data = a | b;
            ex_isa_pkg::OP_AND, ex_isa_pkg::OP_ANDI:   r.rd_data = a & b;
            ex_isa_pkg::OP_ADDW, ex_isa_pkg::OP_ADDIW: r.rd_data = sext32(a[31:0] + b[31:0]);
            ex_isa_pkg::OP_SUBW:                       r.rd_data = sext32(a[31:0] - b[31:0]);
            ex_isa_pkg::OP_SLLW, ex_isa_pkg::OP_SLLIW: r.rd_data = sext32(a[31:0] << b[4:0]);
            ex_isa_pkg::OP_SRLW, ex_isa_pkg::OP_SRLIW: r.rd_data = sext32(a[31:0] >> b[4:0]);
            ex_isa_pkg::OP_SRAW, ex_isa_pkg::OP_SRAIW:
                r.rd_data = sext32($signed(a[31:0]) >>> b[4:0]);
            ex_isa_pkg::OP_LUI:                        r.rd_data = op.imm;
            ex_isa_pkg::OP_AUIPC:                      r.rd_data = op.pc + op.imm;
            ex_isa_pkg::OP_JAL, ex_isa_pkg::OP_JALR:   r.rd_data = op.pc + 64'd4;
            ex_isa_pkg::OP_BEQ:  r.redirect_ena = (a == b);
            ex_isa_pkg::OP_BNE:  r.redirect_ena = (a != b);
            ex_isa_pkg::OP_BLT:  r.redirect_ena = ($signed(a) < $signed(b));
            ex_isa_pkg::OP_BGE:  r.redirect_ena = ($signed(a) >= $signed(b));
            ex_isa_pkg::OP_BLTU: r.redirect_ena = (a < b);
            ex_isa_pkg::OP_BGEU: r.redirect_ena = (a >= b);
            ex_isa_pkg::OP_CSRRW, ex_isa_pkg::OP_CSRRWI: begin
                r.rd_data = old;
                wr = 1'b1;
            end
            ex_isa_pkg::OP_CSRRS, ex_isa_pkg::OP_CSRRSI: begin
                r.rd_data = old;
                wr = (a != 64'd0);
                nxt = old | a;
            end
            ex_isa_pkg::OP_CSRRC, ex_isa_pkg::OP_CSRRCI: begin
                r.rd_data = old;
                wr = (a != 64'd0);
                nxt = old & ~a;
            end
            default: ;
        endcase
        if (take_irq || op.opcode == ex_isa_pkg::OP_ECALL) begin
            r.redirect_ena = 1'b1;
            r.redirect_pc = c.mtvec;
            c.mepc = op.pc;
            c.mcause = take_irq ? `EX_CAUSE_MTIMER : `EX_CAUSE_ECALL;
            c.mstatus[ex_isa_pkg::MSTATUS_MPIE] = c.mstatus[ex_isa_pkg::MSTATUS_MIE];
            c.mstatus[ex_isa_pkg::MSTATUS_MIE] = 1'b0;
        end else if (op.opcode == ex_isa_pkg::OP_MRET) begin
            r.redirect_ena = 1'b1;
            r.redirect_pc = c.mepc;
            c.mstatus[ex_isa_pkg::MSTATUS_MIE] = c.mstatus[ex_isa_pkg::MSTATUS_MPIE];
            c.mstatus[ex_isa_pkg::MSTATUS_MPIE] = 1'b1;
        end else if (wr) begin
            case (idx)
                ex_isa_pkg::CSR_MSTATUS:  c.mstatus = nxt;
                ex_isa_pkg::CSR_MTVEC:    c.mtvec = nxt;
                ex_isa_pkg::CSR_MSCRATCH: c.mscratch = nxt;
                ex_isa_pkg::CSR_MEPC:     c.mepc = nxt;
                ex_isa_pkg::CSR_MCAUSE:   c.mcause = nxt;
                default: ;
            endcase
        end
        return r;
    endfunction

    // four-phase producer; timer_irq_i is held with the op
    task automatic send_op(input ex_isa_pkg::ex_opcode_e opc, input logic [63:0] op1,
                           input logic [63:0] op2, input logic [63:0] imm, input logic irq);
        ex_pipe_pkg::ex_op_t op;
        op.pc = 64'h0000_0000_8000_1000 + 64'(n_sent * 4);
        op.opcode = opc;
        op.op1 = op1;
        op.op2.value = op2;
        op.imm = imm;
        op.rd_addr = 5'(n_sent % 31 + 1);
        op.rd_ena = !(opc inside {ex_isa_pkg::OP_BEQ, ex_isa_pkg::OP_BNE, ex_isa_pkg::OP_BLT,
                                  ex_isa_pkg::OP_BGE, ex_isa_pkg::OP_BLTU, ex_isa_pkg::OP_BGEU,
                                  ex_isa_pkg::OP_ECALL, ex_isa_pkg::OP_MRET});
        exp_q.push_back(ref_exec(op, irq, csr_model));
        n_sent++;
        @(posedge clk);
        #2;
        op_i = op;
        timer_irq_i = irq;
        op_req_i = 1'b1;
        do @(negedge clk); while (!op_ack_o);
        @(posedge clk);
        #2;
        op_req_i = 1'b0;
        do @(negedge clk); while (op_ack_o);
    endtask

    task automatic csr_op(input ex_isa_pkg::ex_opcode_e opc, input logic [11:0] idx,
                          input logic [63:0] val);
        send_op(opc, val, {52'(rand64()), idx}, 64'd0, 1'b0);
    endtask

    task automatic ack_result();
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        #2;
        res_ack_i = 1'b1;
        do @(negedge clk); while (res_req_o);
        @(posedge clk);
        #2;
        res_ack_i = 1'b0;
    endtask

    task automatic report_mismatch(input string field, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Error: %0t %s got %h expected %h", $time, field, got, exp);
        n_errors++;
    endtask

    // compares each offered record, then acknowledges it
    initial begin : compare_results
        ex_pipe_pkg::ex_res_t exp;
        forever begin
            @(negedge clk);
            if (res_req_o && !res_ack_i) begin
                if (exp_q.size() == 0) begin
                    $display("A result was offered at %0t with no operation pending", $time);
                    n_errors++;
                end else begin
                    exp = exp_q.pop_front();
                    if (res_o.rd_ena !== exp.rd_ena)
                        report_mismatch("rd_ena", 64'(res_o.rd_ena), 64'(exp.rd_ena));
                    if (res_o.rd_addr !== exp.rd_addr)
                        report_mismatch("rd_addr", 64'(res_o.rd_addr), 64'(exp.rd_addr));
                    if (exp.rd_ena && res_o.rd_data !== exp.rd_data)
                        report_mismatch("rd_data", res_o.rd_data, exp.rd_data);
                    if (res_o.redirect_ena !== exp.redirect_ena)
                        report_mismatch("redirect_ena", 64'(res_o.redirect_ena),
                                        64'(exp.redirect_ena));
                    if (exp.redirect_ena && res_o.redirect_pc !== exp.redirect_pc)
                        report_mismatch("redirect_pc", res_o.redirect_pc, exp.redirect_pc);
                end
                n_checked++;
                ack_result();
            end
        end
    end

    initial begin : stimulus
        int unsigned seed_ret;
        logic [7:0]  code;
        logic [63:0] x;
        logic [63:0] y;
        logic [11:0] idx_list [5];
        seed_ret = $urandom(32'h7e8a5254);
        rst_n_i = 1'b0;
        op_req_i = 1'b0;
        op_i = '0;
        timer_irq_i = 1'b0;
        res_ack_i = 1'b0;
        csr_model = '0;
        csr_model.mtvec = `EX_MTVEC_RESET;
        repeat (10) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        // register and immediate ALU ops
        for (int i = 0; i < 100; i++) begin
            code = 8'(ex_isa_pkg::OP_ADD) + 8'($urandom % 19);
            send_op(ex_isa_pkg::ex_opcode_e'(code), rand64(), rand64(), 64'd0, 1'b0);
        end
        x = 64'h8000_0000_0000_0000;
        y = 64'h7fff_ffff_ffff_ffff;
        send_op(ex_isa_pkg::OP_SLT, x, y, 64'd0, 1'b0);
        send_op(ex_isa_pkg::OP_SLTU, x, y, 64'd0, 1'b0);
        send_op(ex_isa_pkg::OP_SLT, '1, 64'd0, 64'd0, 1'b0);
        send_op(ex_isa_pkg::OP_SLTU, '1, 64'd0, 64'd0, 1'b0);
        send_op(ex_isa_pkg::OP_SLTI, 64'd0, '1, 64'd0, 1'b0);
        send_op(ex_isa_pkg::OP_SLTIU, 64'd0, '1, 64'd0, 1'b0);
        for (int s = 0; s < 64; s += 63) begin
            send_op(ex_isa_pkg::OP_SLL, x | 64'd1, 64'(s), 64'd0, 1'b0);
            send_op(ex_isa_pkg::OP_SRLI, x | 64'd1, 64'(s), 64'd0, 1'b0);
            send_op(ex_isa_pkg::OP_SRA, x | 64'd1, 64'(s), 64'd0, 1'b0);
        end

        // word ops, upper immediates and link values
        for (int i = 0; i < 40; i++) begin
            code = 8'(ex_isa_pkg::OP_ADDW) + 8'($urandom % 9);
            send_op(ex_isa_pkg::ex_opcode_e'(code), rand64(), rand64(), 64'd0, 1'b0);
        end
        send_op(ex_isa_pkg::OP_ADDW, 64'h7fff_ffff, 64'd1, 64'd0, 1'b0);
        send_op(ex_isa_pkg::OP_SRAIW, 64'h8000_0000, 64'd31, 64'd0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            x = sext32({20'($urandom % 32'h100000), 12'h000});
            send_op(ex_isa_pkg::OP_LUI, 64'd0, 64'd0, x, 1'b0);
            send_op(ex_isa_pkg::OP_AUIPC, 64'd0, 64'd0, x, 1'b0);
            send_op(ex_isa_pkg::OP_JAL, 64'd0, 64'd0, x, 1'b0);
            send_op(ex_isa_pkg::OP_JALR, rand64(), 64'd0, 64'd0, 1'b0);
        end

        // branches on equal, less and greater operands
        for (int k = 0; k < 6; k++) begin
            code = 8'(ex_isa_pkg::OP_BEQ) + 8'(k);
            send_op(ex_isa_pkg::ex_opcode_e'(code), 64'd5, 64'd5, 64'd64, 1'b0);
            send_op(ex_isa_pkg::ex_opcode_e'(code), 64'd3, 64'd7, -64'd32, 1'b0);
            send_op(ex_isa_pkg::ex_opcode_e'(code), '1, 64'd1, 64'd128, 1'b0);
            send_op(ex_isa_pkg::ex_opcode_e'(code), 64'd1, '1, 64'd8, 1'b0);
        end

        // CSR read-modify-write on each supported index
        idx_list = '{ex_isa_pkg::CSR_MSTATUS, ex_isa_pkg::CSR_MTVEC, ex_isa_pkg::CSR_MSCRATCH,
                     ex_isa_pkg::CSR_MEPC, ex_isa_pkg::CSR_MCAUSE};
        for (int i = 0; i < 5; i++) begin
            csr_op(ex_isa_pkg::OP_CSRRW, idx_list[i], rand64());
            csr_op(ex_isa_pkg::OP_CSRRS, idx_list[i], 64'd0);
            csr_op(ex_isa_pkg::OP_CSRRC, idx_list[i], 64'd0);
            csr_op(ex_isa_pkg::OP_CSRRS, idx_list[i], rand64());
            csr_op(ex_isa_pkg::OP_CSRRC, idx_list[i], rand64());
            csr_op(ex_isa_pkg::OP_CSRRWI, idx_list[i], 64'd21);
            csr_op(ex_isa_pkg::OP_CSRRSI, idx_list[i], 64'd10);
            csr_op(ex_isa_pkg::OP_CSRRCI, idx_list[i], 64'd1);
            csr_op(ex_isa_pkg::OP_CSRRSI, idx_list[i], 64'd0);
        end
        csr_op(ex_isa_pkg::OP_CSRRW, 12'h7c0, rand64());
        csr_op(ex_isa_pkg::OP_CSRRS, 12'h7c0, 64'd0);

        // ECALL and MRET
        csr_op(ex_isa_pkg::OP_CSRRW, ex_isa_pkg::CSR_MSTATUS, 64'd0);
        csr_op(ex_isa_pkg::OP_CSRRW, ex_isa_pkg::CSR_MTVEC, 64'h0000_0000_8000_0400);
        send_op(ex_isa_pkg::OP_ECALL, 64'd0, 64'd0, 64'd0, 1'b0);
        csr_op(ex_isa_pkg::OP_CSRRS, ex_isa_pkg::CSR_MEPC, 64'd0);
        csr_op(ex_isa_pkg::OP_CSRRS, ex_isa_pkg::CSR_MCAUSE, 64'd0);
        csr_op(ex_isa_pkg::OP_CSRRW, ex_isa_pkg::CSR_MSTATUS, 64'h80);
        csr_op(ex_isa_pkg::OP_CSRRW, ex_isa_pkg::CSR_MEPC, 64'h0000_0000_8000_2000);
        send_op(ex_isa_pkg::OP_MRET, 64'd0, 64'd0, 64'd0, 1'b0);
        csr_op(ex_isa_pkg::OP_CSRRS, ex_isa_pkg::CSR_MSTATUS, 64'd0);

        // timer interrupt with MIE set, then with MIE clear
        csr_op(ex_isa_pkg::OP_CSRRW, ex_isa_pkg::CSR_MSTATUS, 64'h8);
        send_op(ex_isa_pkg::OP_ADD, rand64(), rand64(), 64'd0, 1'b1);
        csr_op(ex_isa_pkg::OP_CSRRS, ex_isa_pkg::CSR_MCAUSE, 64'd0);
        csr_op(ex_isa_pkg::OP_CSRRS, ex_isa_pkg::CSR_MEPC, 64'd0);
        send_op(ex_isa_pkg::OP_ADD, rand64(), rand64(), 64'd0, 1'b1);
        csr_op(ex_isa_pkg::OP_CSRRW, ex_isa_pkg::CSR_MSTATUS, 64'h8);
        send_op(ex_isa_pkg::OP_BEQ, 64'd9, 64'd9, 64'd16, 1'b1);
        send_op(ex_isa_pkg::OP_SUB, rand64(), rand64(), 64'd0, 1'b1);
        csr_op(ex_isa_pkg::OP_CSRRS, ex_isa_pkg::CSR_MSTATUS, 64'd0);

        while (n_checked != n_sent) @(negedge clk);
        $display("errors: %0d, results checked: %0d of %0d", n_errors, n_checked, n_sent);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
ex_isa_pkg.sv
ex_pipe_pkg.sv
ex_issue.sv
ex_alu.sv
ex_csr.sv
ex_retire.sv
ex_top.sv
tb_ex_top.sv
